// ==== mem_if_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache-side memory interface definitions
// Widths, request and response beats shared by the caches and the
// read arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_if_pkg;

  // Memory bus geometry
  localparam int MEM_DATA_WIDTH    = 64;
  localparam int MEM_ADDR_WIDTH    = 32;
  localparam int MEM_ID_WIDTH      = 4;

  // Instruction cache refill line
  localparam int ICACHE_LINE_WIDTH = 128;
  localparam int ICACHE_BEATS      = ICACHE_LINE_WIDTH / MEM_DATA_WIDTH;

  localparam int NUM_READERS       = 3;

  typedef logic [MEM_DATA_WIDTH-1:0]    mem_data_t;
  typedef logic [MEM_ADDR_WIDTH-1:0]    mem_addr_t;
  typedef logic [MEM_ID_WIDTH-1:0]      mem_id_t;
  typedef logic [ICACHE_LINE_WIDTH-1:0] icache_line_t;

  // Burst length minus one and log2 of bytes per beat
  typedef logic [7:0] mem_len_t;
  typedef logic [2:0] mem_size_t;

  typedef logic [1:0] reader_idx_t;

  // Requester slots on the read arbiter
  localparam reader_idx_t RD_ICACHE  = 2'd0;
  localparam reader_idx_t RD_DC_MISS = 2'd1;
  localparam reader_idx_t RD_UC_READ = 2'd2;

  typedef struct packed {
    mem_addr_t addr;
    mem_len_t  len;
    mem_size_t size;
    mem_id_t   id;
    logic      cacheable;
  } mem_req_t;

  // One read beat back toward a requester
  typedef struct packed {
    mem_id_t   id;
    mem_data_t data;
    logic      error;
    logic      last;
  } mem_resp_t;

endpackage

// ==== axi_rd_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read channel definitions
// AR and R payloads with burst and response encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axi_rd_pkg;

  typedef logic [1:0] axi_burst_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_burst_t AXI_BURST_INCR  = 2'b01;

  localparam axi_resp_t  AXI_RESP_OKAY   = 2'b00;
  localparam axi_resp_t  AXI_RESP_SLVERR = 2'b10;

  // Read address channel
  typedef struct packed {
    mem_if_pkg::mem_id_t   id;
    mem_if_pkg::mem_addr_t addr;
    mem_if_pkg::mem_len_t  len;
    mem_if_pkg::mem_size_t size;
    axi_burst_t            burst;
  } axi_ar_t;

  // Read data channel
  typedef struct packed {
    mem_if_pkg::mem_id_t   id;
    mem_if_pkg::mem_data_t data;
    axi_resp_t             resp;
    logic                  last;
  } axi_r_t;

endpackage

// ==== read_req_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read request arbiter
// Builds the instruction miss request, parks it in a one-entry slot and
// grants the three read requesters round-robin
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module read_req_arbiter (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,

  input  wire logic                  icache_miss_valid_i,
  input  wire mem_if_pkg::mem_addr_t icache_miss_paddr_i,
  input  wire mem_if_pkg::mem_id_t   icache_miss_id_i,
  output logic                       icache_miss_ready_o,

  input  wire logic                  dc_miss_valid_i,
  input  wire mem_if_pkg::mem_req_t  dc_miss_req_i,
  output logic                       dc_miss_ready_o,

  input  wire logic                  uc_read_valid_i,
  input  wire mem_if_pkg::mem_req_t  uc_read_req_i,
  output logic                       uc_read_ready_o,

  output logic                       req_valid_o,
  output mem_if_pkg::mem_req_t       req_o,
  input  wire logic                  req_ready_i
);

  import mem_if_pkg::*;

  logic                   slot_valid_q;
  mem_req_t               slot_q;
  mem_req_t               icache_req;
  logic                   slot_load;

  logic [NUM_READERS-1:0] rd_valid;
  mem_req_t               rd_req [NUM_READERS];
  logic [NUM_READERS-1:0] rd_ready;

  reader_idx_t            ptr_q;
  reader_idx_t            rr_idx;
  reader_idx_t            gnt_idx;
  logic                   lock_q;
  reader_idx_t            lock_idx_q;
  logic                   ar_fire;

  // Full line refill from the instruction cache
  always_comb begin
    icache_req.addr      = icache_miss_paddr_i;
    icache_req.len       = mem_len_t'(ICACHE_BEATS - 1);
    icache_req.size      = mem_size_t'($clog2(MEM_DATA_WIDTH / 8));
    icache_req.id        = icache_miss_id_i;
    icache_req.cacheable = 1'b1;
  end

  // The icache may withdraw its valid, so the request is captured here
  assign slot_load           = icache_miss_valid_i && !slot_valid_q;
  assign icache_miss_ready_o = !slot_valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_valid_q <= 1'b0;
    end else if (slot_load) begin
      slot_valid_q <= 1'b1;
    end else if (rd_ready[RD_ICACHE]) begin
      slot_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot_load) begin
      slot_q <= icache_req;
    end
  end

  assign rd_valid[RD_ICACHE]  = slot_valid_q;
  assign rd_valid[RD_DC_MISS] = dc_miss_valid_i;
  assign rd_valid[RD_UC_READ] = uc_read_valid_i;

  assign rd_req[RD_ICACHE]    = slot_q;
  assign rd_req[RD_DC_MISS]   = dc_miss_req_i;
  assign rd_req[RD_UC_READ]   = uc_read_req_i;

  // First valid requester at or after the pointer
  always_comb begin
    int unsigned cand;
    rr_idx = ptr_q;
    for (int k = NUM_READERS - 1; k >= 0; k--) begin
      cand = (int'(ptr_q) + k) % NUM_READERS;
      if (rd_valid[cand]) begin
        rr_idx = reader_idx_t'(cand);
      end
    end
  end

  // A stalled grant stays put so AR never changes under valid
  assign gnt_idx     = lock_q ? lock_idx_q : rr_idx;
  assign req_valid_o = rd_valid[gnt_idx];
  assign req_o       = rd_req[gnt_idx];
  assign ar_fire     = req_valid_o && req_ready_i;

  always_comb begin
    rd_ready          = '0;
    rd_ready[gnt_idx] = ar_fire;
  end

  assign dc_miss_ready_o = rd_ready[RD_DC_MISS];
  assign uc_read_ready_o = rd_ready[RD_UC_READ];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q      <= RD_ICACHE;
      lock_q     <= 1'b0;
      lock_idx_q <= RD_ICACHE;
    end else begin
      if (ar_fire) begin
        ptr_q <= (gnt_idx == reader_idx_t'(NUM_READERS - 1)) ? RD_ICACHE : gnt_idx + 2'd1;
      end
      lock_q     <= req_valid_o && !req_ready_i;
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

// ==== axi_read_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read port
// Drives AR from the granted request and registers R beats as responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axi_read_port (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,

  input  wire logic                  req_valid_i,
  input  wire mem_if_pkg::mem_req_t  req_i,
  output logic                       req_ready_o,

  output logic                       axi_ar_valid_o,
  output axi_rd_pkg::axi_ar_t        axi_ar_o,
  input  wire logic                  axi_ar_ready_i,

  input  wire logic                  axi_r_valid_i,
  input  wire axi_rd_pkg::axi_r_t    axi_r_i,
  output logic                       axi_r_ready_o,

  output logic                       resp_valid_o,
  output mem_if_pkg::mem_resp_t      resp_o,
  input  wire logic                  resp_ready_i
);

  import mem_if_pkg::*;
  import axi_rd_pkg::*;

  logic      resp_valid_q;
  mem_resp_t resp_q;
  logic      r_fire;

  // AR follows the granted request directly
  assign axi_ar_valid_o = req_valid_i;
  assign req_ready_o    = axi_ar_ready_i;

  always_comb begin
    axi_ar_o.id    = req_i.id;
    axi_ar_o.addr  = req_i.addr;
    axi_ar_o.len   = req_i.len;
    axi_ar_o.size  = req_i.size;
    axi_ar_o.burst = AXI_BURST_INCR;
  end

  // Output register takes a beat when empty or draining
  assign axi_r_ready_o = !resp_valid_q || resp_ready_i;
  assign r_fire        = axi_r_valid_i && axi_r_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (r_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_fire) begin
      resp_q.id    <= axi_r_i.id;
      resp_q.data  <= axi_r_i.data;
      resp_q.error <= (axi_r_i.resp != AXI_RESP_OKAY);
      resp_q.last  <= axi_r_i.last;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

// ==== read_resp_router.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read response router
// Steers response beats to their requester by ID and gathers
// instruction cache beats into full lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module read_resp_router (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,

  input  wire logic                     resp_valid_i,
  input  wire mem_if_pkg::mem_resp_t    resp_i,
  output logic                          resp_ready_o,

  input  wire mem_if_pkg::mem_id_t      icache_miss_id_i,
  input  wire mem_if_pkg::mem_id_t      uc_read_id_i,

  output logic                          icache_miss_resp_valid_o,
  output mem_if_pkg::icache_line_t      icache_miss_resp_data_o,
  output mem_if_pkg::mem_id_t           icache_miss_resp_id_o,

  output logic                          dc_miss_resp_valid_o,
  output mem_if_pkg::mem_resp_t         dc_miss_resp_o,
  input  wire logic                     dc_miss_resp_ready_i,

  output logic                          uc_read_resp_valid_o,
  output mem_if_pkg::mem_resp_t         uc_read_resp_o,
  input  wire logic                     uc_read_resp_ready_i
);

  import mem_if_pkg::*;

  reader_idx_t  dest;
  logic         icache_ready;
  logic         icache_fire;

  // Line assembly state
  logic         line_pend_q;
  icache_line_t line_q;
  mem_id_t      line_id_q;

  // Icache ID wins over the uncached ID, everything else is a refill
  always_comb begin
    if (resp_i.id == icache_miss_id_i) begin
      dest = RD_ICACHE;
    end else if (resp_i.id == uc_read_id_i) begin
      dest = RD_UC_READ;
    end else begin
      dest = RD_DC_MISS;
    end
  end

  // No beats while a finished line waits for its pulse
  assign icache_ready = !line_pend_q;

  always_comb begin
    case (dest)
      RD_ICACHE:  resp_ready_o = icache_ready;
      RD_UC_READ: resp_ready_o = uc_read_resp_ready_i;
      default:    resp_ready_o = dc_miss_resp_ready_i;
    endcase
  end

  // Data cache ports see the beat unchanged
  assign dc_miss_resp_valid_o = resp_valid_i && (dest == RD_DC_MISS);
  assign dc_miss_resp_o       = resp_i;

  assign uc_read_resp_valid_o = resp_valid_i && (dest == RD_UC_READ);
  assign uc_read_resp_o       = resp_i;

  assign icache_fire = resp_valid_i && (dest == RD_ICACHE) && icache_ready;

  // Pulse for exactly one cycle after the last beat
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      line_pend_q <= 1'b0;
    end else begin
      line_pend_q <= icache_fire && resp_i.last;
    end
  end

  // Beats shift in from the top so beat 0 lands in the low half
  always_ff @(posedge clk_i) begin
    if (icache_fire) begin
      line_q <= {resp_i.data, line_q[ICACHE_LINE_WIDTH-1:MEM_DATA_WIDTH]};
      if (resp_i.last) begin
        line_id_q <= resp_i.id;
      end
    end
  end

  assign icache_miss_resp_valid_o = line_pend_q;
  assign icache_miss_resp_data_o  = line_q;
  assign icache_miss_resp_id_o    = line_id_q;

endmodule

// ==== cache_axi_read_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache to AXI read arbiter
// Merges the icache miss, dcache miss and uncached read requesters onto
// one AXI read channel pair and routes the beats back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_axi_read_arbiter (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,

  // Instruction cache
  input  wire logic                     icache_miss_valid_i,
  output logic                          icache_miss_ready_o,
  input  wire mem_if_pkg::mem_addr_t    icache_miss_paddr_i,
  input  wire mem_if_pkg::mem_id_t      icache_miss_id_i,
  output logic                          icache_miss_resp_valid_o,
  output mem_if_pkg::icache_line_t      icache_miss_resp_data_o,
  output mem_if_pkg::mem_id_t           icache_miss_resp_id_o,

  // Data cache refill
  input  wire logic                     dc_miss_valid_i,
  input  wire mem_if_pkg::mem_req_t     dc_miss_req_i,
  output logic                          dc_miss_ready_o,
  output logic                          dc_miss_resp_valid_o,
  output mem_if_pkg::mem_resp_t         dc_miss_resp_o,
  input  wire logic                     dc_miss_resp_ready_i,

  // Data cache uncached read
  input  wire logic                     uc_read_valid_i,
  input  wire mem_if_pkg::mem_req_t     uc_read_req_i,
  output logic                          uc_read_ready_o,
  input  wire mem_if_pkg::mem_id_t      uc_read_id_i,
  output logic                          uc_read_resp_valid_o,
  output mem_if_pkg::mem_resp_t         uc_read_resp_o,
  input  wire logic                     uc_read_resp_ready_i,

  // AXI read channels
  output logic                          axi_ar_valid_o,
  output axi_rd_pkg::axi_ar_t           axi_ar_o,
  input  wire logic                     axi_ar_ready_i,
  input  wire logic                     axi_r_valid_i,
  input  wire axi_rd_pkg::axi_r_t       axi_r_i,
  output logic                          axi_r_ready_o
);

  import mem_if_pkg::*;

  logic      req_valid;
  mem_req_t  req;
  logic      req_ready;

  logic      resp_valid;
  mem_resp_t resp;
  logic      resp_ready;

  read_req_arbiter i_read_req_arbiter (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .icache_miss_valid_i (icache_miss_valid_i),
    .icache_miss_paddr_i (icache_miss_paddr_i),
    .icache_miss_id_i    (icache_miss_id_i),
    .icache_miss_ready_o (icache_miss_ready_o),
    .dc_miss_valid_i     (dc_miss_valid_i),
    .dc_miss_req_i       (dc_miss_req_i),
    .dc_miss_ready_o     (dc_miss_ready_o),
    .uc_read_valid_i     (uc_read_valid_i),
    .uc_read_req_i       (uc_read_req_i),
    .uc_read_ready_o     (uc_read_ready_o),
    .req_valid_o         (req_valid),
    .req_o               (req),
    .req_ready_i         (req_ready)
  );

  axi_read_port i_axi_read_port (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .req_ready_o    (req_ready),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_o       (axi_ar_o),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_i        (axi_r_i),
    .axi_r_ready_o  (axi_r_ready_o),
    .resp_valid_o   (resp_valid),
    .resp_o         (resp),
    .resp_ready_i   (resp_ready)
  );

  read_resp_router i_read_resp_router (
    .clk_i                    (clk_i),
    .arst_n_i                 (arst_n_i),
    .resp_valid_i             (resp_valid),
    .resp_i                   (resp),
    .resp_ready_o             (resp_ready),
    .icache_miss_id_i         (icache_miss_id_i),
    .uc_read_id_i             (uc_read_id_i),
    .icache_miss_resp_valid_o (icache_miss_resp_valid_o),
    .icache_miss_resp_data_o  (icache_miss_resp_data_o),
    .icache_miss_resp_id_o    (icache_miss_resp_id_o),
    .dc_miss_resp_valid_o     (dc_miss_resp_valid_o),
    .dc_miss_resp_o           (dc_miss_resp_o),
    .dc_miss_resp_ready_i     (dc_miss_resp_ready_i),
    .uc_read_resp_valid_o     (uc_read_resp_valid_o),
    .uc_read_resp_o           (uc_read_resp_o),
    .uc_read_resp_ready_i     (uc_read_resp_ready_i)
  );

endmodule

// ==== cache_axi_read_arbiter_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks for the cache to AXI read arbiter
// AR stability, R back-pressure and icache line pulse timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_axi_read_arbiter_asserts (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  input  wire logic                  axi_ar_valid_i,
  input  wire axi_rd_pkg::axi_ar_t   axi_ar_i,
  input  wire logic                  axi_ar_ready_i,
  input  wire logic                  axi_r_valid_i,
  input  wire axi_rd_pkg::axi_r_t    axi_r_i,
  input  wire logic                  axi_r_ready_i,
  input  wire logic                  resp_valid_i,
  input  wire mem_if_pkg::mem_resp_t resp_i,
  input  wire logic                  resp_ready_i,
  input  wire mem_if_pkg::mem_id_t   icache_id_i,
  input  wire logic                  icache_resp_valid_i
);

  int err_count = 0;

  // Stalled AR keeps valid and payload
  ar_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    axi_ar_valid_i && !axi_ar_ready_i |=> axi_ar_valid_i && $stable(axi_ar_i))
  else begin
    $error("AR valid or payload changed while stalled");
    err_count++;
  end

  // Full and stalled response register blocks R and keeps its beat
  r_blocked_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i |-> !axi_r_ready_i ##1 (resp_valid_i && $stable(resp_i)))
  else begin
    $error("R ready high or response beat lost while the response register is stalled");
    err_count++;
  end

  // Line pulse two cycles after the last icache beat on R, one cycle wide
  icache_pulse_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    axi_r_valid_i && axi_r_ready_i && axi_r_i.last && (axi_r_i.id == icache_id_i)
    |-> ##2 icache_resp_valid_i ##1 !icache_resp_valid_i)
  else begin
    $error("Icache line valid missing or high for two cycles in a row");
    err_count++;
  end

endmodule

// ==== cache_axi_read_arbiter_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the cache to AXI read arbiter
// Drives the three read requesters against an AXI memory model with
// random stalls and checks the routed responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cache_axi_read_arbiter_tb;

  import mem_if_pkg::*;
  import axi_rd_pkg::*;

  localparam int TIMEOUT  = 2000;
  localparam int NUM_STIM = 7;

  typedef struct packed {
    reader_idx_t who;
    mem_addr_t   addr;
    mem_len_t    len;
    mem_id_t     id;
    logic        bp;
  } stim_t;

  logic         clk_i;
  logic         arst_n_i;
  logic         icache_miss_valid_i;
  logic         icache_miss_ready_o;
  mem_addr_t    icache_miss_paddr_i;
  mem_id_t      icache_miss_id_i;
  logic         icache_miss_resp_valid_o;
  icache_line_t icache_miss_resp_data_o;
  mem_id_t      icache_miss_resp_id_o;
  logic         dc_miss_valid_i;
  mem_req_t     dc_miss_req_i;
  logic         dc_miss_ready_o;
  logic         dc_miss_resp_valid_o;
  mem_resp_t    dc_miss_resp_o;
  logic         dc_miss_resp_ready_i;
  logic         uc_read_valid_i;
  mem_req_t     uc_read_req_i;
  logic         uc_read_ready_o;
  mem_id_t      uc_read_id_i;
  logic         uc_read_resp_valid_o;
  mem_resp_t    uc_read_resp_o;
  logic         uc_read_resp_ready_i;
  logic         axi_ar_valid_o;
  axi_ar_t      axi_ar_o;
  logic         axi_ar_ready_i;
  logic         axi_r_valid_i;
  axi_r_t       axi_r_i;
  logic         axi_r_ready_o;

  // Memory model and response capture
  axi_ar_t      burst_q [$];
  axi_ar_t      ar_q [$];
  int           beat_idx;
  logic [31:0]  rng_state = 32'h8287;
  mem_resp_t    dc_q [$];
  mem_resp_t    uc_q [$];
  icache_line_t line_q [$];
  mem_id_t      line_id_q [$];
  stim_t        stim [NUM_STIM];

  cache_axi_read_arbiter dut (.*);

  bind cache_axi_read_arbiter cache_axi_read_arbiter_asserts u_asserts (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .axi_ar_valid_i      (axi_ar_valid_o),
    .axi_ar_i            (axi_ar_o),
    .axi_ar_ready_i      (axi_ar_ready_i),
    .axi_r_valid_i       (axi_r_valid_i),
    .axi_r_i             (axi_r_i),
    .axi_r_ready_i       (axi_r_ready_o),
    .resp_valid_i        (resp_valid),
    .resp_i              (resp),
    .resp_ready_i        (resp_ready),
    .icache_id_i         (icache_miss_id_i),
    .icache_resp_valid_i (icache_miss_resp_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Destination by ID, icache first, then uncached, else refill
  function automatic reader_idx_t route_of(input mem_id_t id);
    reader_idx_t r;
    if (id == icache_miss_id_i) begin
      r = RD_ICACHE;
    end else if (id == uc_read_id_i) begin
      r = RD_UC_READ;
    end else begin
      r = RD_DC_MISS;
    end
    return r;
  endfunction

  // Beat k of address A carries A above k
  function automatic mem_resp_t expected_beat(input mem_addr_t addr, input mem_id_t id,
                                              input int k, input mem_len_t len);
    mem_resp_t r;
    r.id    = id;
    r.data  = {addr, 32'(k)};
    r.error = addr[31];
    r.last  = (k == int'(len));
    return r;
  endfunction

  function automatic icache_line_t expected_line(input mem_addr_t addr);
    icache_line_t line;
    for (int k = 0; k < ICACHE_BEATS; k++) begin
      line[k*MEM_DATA_WIDTH +: MEM_DATA_WIDTH] = {addr, 32'(k)};
    end
    return line;
  endfunction

  // INCR burst of 8-byte beats, icache always asks for a full line
  function automatic axi_ar_t expected_ar(input stim_t s);
    axi_ar_t a;
    a.id    = (s.who == RD_ICACHE) ? icache_miss_id_i : s.id;
    a.addr  = s.addr;
    a.len   = (s.who == RD_ICACHE) ? mem_len_t'(ICACHE_BEATS - 1) : s.len;
    a.size  = 3'd3;
    a.burst = AXI_BURST_INCR;
    return a;
  endfunction

  function automatic mem_req_t make_req(input stim_t s);
    mem_req_t r;
    r.addr      = s.addr;
    r.len       = s.len;
    r.size      = mem_size_t'($clog2(MEM_DATA_WIDTH / 8));
    r.id        = s.id;
    r.cacheable = (s.who == RD_DC_MISS);
    return r;
  endfunction

  function automatic int responses_seen(input reader_idx_t port);
    int n;
    case (port)
      RD_ICACHE:  n = line_q.size();
      RD_UC_READ: n = uc_q.size();
      default:    n = dc_q.size();
    endcase
    return n;
  endfunction

  function automatic logic ready_of(input reader_idx_t who);
    logic r;
    case (who)
      RD_ICACHE:  r = icache_miss_ready_o;
      RD_DC_MISS: r = dc_miss_ready_o;
      default:    r = uc_read_ready_o;
    endcase
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_line(input string name, input icache_line_t exp, input icache_line_t act);
    if (exp !== act) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_resp(input string name, input mem_resp_t exp, input mem_resp_t act);
    if (exp !== act) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_ar(input string name, input axi_ar_t exp, input axi_ar_t act);
    if (exp !== act) begin
      abort_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_id(input string name, input mem_id_t exp, input mem_id_t act);
    if (exp !== act) begin
      abort_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      abort_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_beats(input string name, input reader_idx_t port, input int base,
                             input mem_addr_t addr, input mem_len_t len, input mem_id_t id);
    mem_resp_t act;
    for (int k = 0; k <= int'(len); k++) begin
      act = (port == RD_UC_READ) ? uc_q[base + k] : dc_q[base + k];
      check_resp($sformatf("%s beat %0d", name, k), expected_beat(addr, id, k, len), act);
    end
  endtask

  task automatic wait_responses(input string name, input reader_idx_t port, input int target);
    int cycles;
    cycles = 0;
    while (responses_seen(port) < target && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (responses_seen(port) < target) begin
      abort_run($sformatf("Timeout waiting for the %s responses", name));
    end
  endtask

  task automatic wait_dc_valid(input string name);
    int cycles;
    cycles = 0;
    while (!dc_miss_resp_valid_o && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!dc_miss_resp_valid_o) begin
      abort_run($sformatf("Timeout waiting for the first %s dcache response", name));
    end
  endtask

  // Hold one request until its handshake, then drop valid
  task automatic issue_request(input stim_t s);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    case (s.who)
      RD_ICACHE: begin
        icache_miss_valid_i <= 1'b1;
        icache_miss_paddr_i <= s.addr;
      end
      RD_DC_MISS: begin
        dc_miss_valid_i <= 1'b1;
        dc_miss_req_i   <= make_req(s);
      end
      default: begin
        uc_read_valid_i <= 1'b1;
        uc_read_req_i   <= make_req(s);
      end
    endcase
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
      done = ready_of(s.who);
    end
    icache_miss_valid_i <= 1'b0;
    dc_miss_valid_i     <= 1'b0;
    uc_read_valid_i     <= 1'b0;
    if (!done) begin
      abort_run("Timeout waiting for a request handshake");
    end
  endtask

  // All three requesters valid at the arbiter in one cycle
  task automatic run_order_test();
    stim_t ic_s;
    stim_t dc_s;
    stim_t uc_s;
    logic  dc_busy;
    logic  uc_busy;
    int    cycles;
    ic_s = '{RD_ICACHE, 32'h0000_5000, 8'd1, 4'd1, 1'b0};
    dc_s = '{RD_DC_MISS, 32'h0000_6000, 8'd1, 4'd9, 1'b0};
    uc_s = '{RD_UC_READ, 32'h0000_7010, 8'd0, 4'd2, 1'b0};
    issue_request(ic_s);
    dc_miss_valid_i <= 1'b1;
    dc_miss_req_i   <= make_req(dc_s);
    uc_read_valid_i <= 1'b1;
    uc_read_req_i   <= make_req(uc_s);
    dc_busy = 1'b1;
    uc_busy = 1'b1;
    cycles  = 0;
    while ((dc_busy || uc_busy) && cycles < TIMEOUT) begin
      @(posedge clk_i);
      cycles++;
      if (dc_busy && dc_miss_ready_o) begin
        dc_miss_valid_i <= 1'b0;
        dc_busy = 1'b0;
      end
      if (uc_busy && uc_read_ready_o) begin
        uc_read_valid_i <= 1'b0;
        uc_busy = 1'b0;
      end
    end
    if (dc_busy || uc_busy) begin
      abort_run("Timeout waiting for the concurrent request handshakes");
    end
    wait_responses("order icache", RD_ICACHE, 1);
    wait_responses("order dcache", RD_DC_MISS, 2);
    wait_responses("order uncached", RD_UC_READ, 1);
    check_count("order AR count", 3, ar_q.size());
    check_ar("order AR 0", expected_ar(ic_s), ar_q[0]);
    check_ar("order AR 1", expected_ar(dc_s), ar_q[1]);
    check_ar("order AR 2", expected_ar(uc_s), ar_q[2]);
    check_line("order icache line", expected_line(ic_s.addr), line_q[0]);
    check_id("order icache id", ic_s.id, line_id_q[0]);
    check_beats("order dcache", RD_DC_MISS, 0, dc_s.addr, dc_s.len, dc_s.id);
    check_beats("order uncached", RD_UC_READ, 0, uc_s.addr, uc_s.len, uc_s.id);
  endtask

  task automatic run_stim(input stim_t s, input int n);
    string       name;
    reader_idx_t dest;
    int          beats;
    int          n_dc;
    int          n_uc;
    int          n_line;
    int          n_ar;
    name   = $sformatf("stim%0d", n);
    dest   = (s.who == RD_ICACHE) ? RD_ICACHE : route_of(s.id);
    beats  = int'(s.len) + 1;
    n_dc   = dc_q.size();
    n_uc   = uc_q.size();
    n_line = line_q.size();
    n_ar   = ar_q.size();
    if (s.bp) begin
      dc_miss_resp_ready_i <= 1'b0;
    end
    issue_request(s);
    // Hold the refill port off for a while once a beat waits
    if (s.bp) begin
      wait_dc_valid(name);
      repeat (6) @(posedge clk_i);
      dc_miss_resp_ready_i <= 1'b1;
    end
    case (dest)
      RD_ICACHE: begin
        wait_responses(name, RD_ICACHE, n_line + 1);
        check_line({name, " line"}, expected_line(s.addr), line_q[n_line]);
        check_id({name, " line id"}, s.id, line_id_q[n_line]);
        n_line++;
      end
      RD_UC_READ: begin
        wait_responses(name, RD_UC_READ, n_uc + beats);
        check_beats(name, RD_UC_READ, n_uc, s.addr, s.len, s.id);
        n_uc += beats;
      end
      default: begin
        wait_responses(name, RD_DC_MISS, n_dc + beats);
        check_beats(name, RD_DC_MISS, n_dc, s.addr, s.len, s.id);
        n_dc += beats;
      end
    endcase
    check_count({name, " dcache count"}, n_dc, dc_q.size());
    check_count({name, " uncached count"}, n_uc, uc_q.size());
    check_count({name, " icache count"}, n_line, line_q.size());
    check_count({name, " AR count"}, n_ar + 1, ar_q.size());
    check_ar({name, " AR"}, expected_ar(s), ar_q[n_ar]);
  endtask

  // AXI memory with random AR and R stalls
  always @(posedge clk_i) begin
    axi_ar_t     cur;
    logic [31:0] rnd;
    rng_state = lcg_next(rng_state);
    rnd       = rng_state;
    if (!arst_n_i) begin
      axi_ar_ready_i <= 1'b0;
      axi_r_valid_i  <= 1'b0;
      beat_idx = 0;
    end else begin
      if (axi_ar_valid_o && axi_ar_ready_i) begin
        burst_q.push_back(axi_ar_o);
        ar_q.push_back(axi_ar_o);
      end
      if (axi_r_valid_i && axi_r_ready_o) begin
        if (axi_r_i.last) begin
          void'(burst_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
      axi_ar_ready_i <= (rnd[17:16] != 2'b00);
      // A presented beat holds until R ready
      if (!(axi_r_valid_i && !axi_r_ready_o)) begin
        if (burst_q.size() > 0 && rnd[25:24] != 2'b00) begin
          cur = burst_q[0];
          axi_r_valid_i <= 1'b1;
          axi_r_i.id    <= cur.id;
          axi_r_i.data  <= {cur.addr, 32'(beat_idx)};
          axi_r_i.resp  <= cur.addr[31] ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
          axi_r_i.last  <= (beat_idx == int'(cur.len));
        end else begin
          axi_r_valid_i <= 1'b0;
        end
      end
    end
  end

  // Handshakes captured mid-cycle where outputs are settled
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (dc_miss_resp_valid_o && dc_miss_resp_ready_i) begin
        dc_q.push_back(dc_miss_resp_o);
      end
      if (uc_read_resp_valid_o && uc_read_resp_ready_i) begin
        uc_q.push_back(uc_read_resp_o);
      end
      if (icache_miss_resp_valid_o) begin
        line_q.push_back(icache_miss_resp_data_o);
        line_id_q.push_back(icache_miss_resp_id_o);
      end
    end
  end

  initial begin
    arst_n_i             = 1'b0;
    icache_miss_valid_i  = 1'b0;
    icache_miss_paddr_i  = '0;
    icache_miss_id_i     = 4'd1;
    dc_miss_valid_i      = 1'b0;
    dc_miss_req_i        = '0;
    dc_miss_resp_ready_i = 1'b1;
    uc_read_valid_i      = 1'b0;
    uc_read_req_i        = '0;
    uc_read_id_i         = 4'd2;
    uc_read_resp_ready_i = 1'b1;
    axi_ar_ready_i       = 1'b0;
    axi_r_valid_i        = 1'b0;
    axi_r_i              = '0;
    // Requester, address, length, ID, refill back-pressure
    stim[0] = '{RD_ICACHE,  32'h0000_1000, 8'd1, 4'd1, 1'b0};
    stim[1] = '{RD_DC_MISS, 32'h0000_2040, 8'd3, 4'd5, 1'b0};
    stim[2] = '{RD_UC_READ, 32'h0000_3008, 8'd0, 4'd2, 1'b0};
    stim[3] = '{RD_DC_MISS, 32'h0000_4000, 8'd3, 4'd6, 1'b1};
    stim[4] = '{RD_DC_MISS, 32'h8000_0100, 8'd1, 4'd7, 1'b0};
    stim[5] = '{RD_UC_READ, 32'h8000_0200, 8'd0, 4'd2, 1'b0};
    stim[6] = '{RD_ICACHE,  32'h8000_0300, 8'd1, 4'd1, 1'b0};
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    run_order_test();
    for (int i = 0; i < NUM_STIM; i++) begin
      run_stim(stim[i], i);
    end
    if (dut.u_asserts.err_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1, "Protocol assertions failed");
    end
  end

endmodule

// ==== verilog.f ====
mem_if_pkg.sv
axi_rd_pkg.sv
read_req_arbiter.sv
axi_read_port.sv
read_resp_router.sv
cache_axi_read_arbiter.sv
cache_axi_read_arbiter_asserts.sv
cache_axi_read_arbiter_tb.sv
